// ==== rtl/glbl_reg_defines.svh ====
/*
 * Global register block constants
 * Register word addresses, strap bit positions,
 * reset values and reset-control bit positions
 */
`ifndef GLBL_REG_DEFINES_SVH
`define GLBL_REG_DEFINES_SVH

// Register word addresses
`define ADDR_CHIP_ID              5'd0
`define ADDR_RST_CTRL             5'd1
`define ADDR_GLBL_CFG             5'd2
`define ADDR_INTR_MASK            5'd3
`define ADDR_INTR_STAT            5'd4
`define ADDR_MFUNC_SEL            5'd5
`define ADDR_SYS_STRAP            5'd14
`define ADDR_MAILBOX              5'd15
// First of four scratch words, 16 to 19
`define ADDR_SCRATCH0             5'd16

// System strap bit positions
`define STRAP_RISCV_RESET_MODE    2
`define STRAP_RISCV_CACHE_BYPASS  3
`define STRAP_RISCV_SRAM_CLK_EDGE 4

// Chip identity fields
`define CHIP_MANU_ID              16'h8268
`define CHIP_TOTAL_CORE           4'h1
`define CHIP_NUM                  4'h5
`define CHIP_REV                  8'h01
`define CHIP_ID_VALUE  {`CHIP_MANU_ID, `CHIP_TOTAL_CORE, `CHIP_NUM, `CHIP_REV}

// Reset values
`define RST_CTRL_BOOT             10'h103
`define RST_CTRL_HOLD             10'h003
`define MFUNC_SEL_RESET           32'h8000_0000
`define SCRATCH0_SIGNATURE        32'h8273_8343

// Reset-control bit positions, all active low
`define RST_BIT_CPU_INTF          0
`define RST_BIT_QSPIM             1
`define RST_BIT_SSPIM             2
`define RST_BIT_UART0             3
`define RST_BIT_I2CM              4
`define RST_BIT_USB               5
`define RST_BIT_UART1             6
`define RST_BIT_CPU0              8
`define RST_BIT_CPU1              9

`endif

// ==== rtl/glbl_reg_pkg.sv ====
/*
 * Shared vector types of the global register block
 * Bus word, address, byte enables, write strobes,
 * strap word, interrupt vector and reset-control field
 */
package glbl_reg_pkg;

   // Register data word
   typedef logic [31:0] reg_word_t;

   // Register word address, 32 locations
   typedef logic [4:0]  reg_addr_t;

   // One enable per byte lane
   typedef logic [3:0]  reg_be_t;

   // One-hot write strobe, one bit per address
   typedef logic [31:0] reg_strb_t;

   // System strap word
   typedef logic [31:0] strap_t;

   // Interrupt request, status, mask and lines
   typedef logic [31:0] intr_vec_t;

   // Reset-control bits of register 1
   typedef logic [9:0]  rst_ctrl_t;

endpackage

// ==== rtl/reg_bus_ctrl.sv ====
/*
 * Register bus slave
 * Address decode into one-hot write strobes,
 * registered acknowledge and read-data multiplexer
 */
`timescale 1ns/10ps
`include "glbl_reg_defines.svh"

module reg_bus_ctrl (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   // Bus request side
   input  logic                    reg_cs,
   input  logic                    reg_wr,
   input  glbl_reg_pkg::reg_addr_t reg_addr,
   input  glbl_reg_pkg::reg_word_t reg_wdata,
   input  glbl_reg_pkg::reg_be_t   reg_be,
   // Readback sources
   input  glbl_reg_pkg::strap_t    system_strap,
   input  glbl_reg_pkg::rst_ctrl_t rst_ctrl,
   input  glbl_reg_pkg::reg_word_t glbl_cfg,
   input  glbl_reg_pkg::intr_vec_t intr_mask,
   input  glbl_reg_pkg::intr_vec_t intr_stat,
   input  glbl_reg_pkg::reg_word_t mfunc_sel,
   input  glbl_reg_pkg::reg_word_t mailbox,
   input  glbl_reg_pkg::reg_word_t scratch [4],
   // Write path to the register blocks
   output glbl_reg_pkg::reg_strb_t wr_strb,
   output glbl_reg_pkg::reg_word_t wr_data,
   output glbl_reg_pkg::reg_be_t   wr_be,
   // Bus response side
   output glbl_reg_pkg::reg_word_t reg_rdata,
   output logic                    reg_ack
);

   import glbl_reg_pkg::*;

   logic      wr_req;
   reg_word_t rd_mux;

   // ----------------------------------------
   // Write decode
   // ----------------------------------------
   // Request not yet acked, so one write per access
   assign wr_req  = reg_cs & reg_wr & ~reg_ack;
   assign wr_strb = wr_req ? (reg_strb_t'(1) << reg_addr) : '0;
   assign wr_data = reg_wdata;
   assign wr_be   = reg_be;

   // ----------------------------------------
   // Read multiplexer
   // ----------------------------------------
   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         `ADDR_CHIP_ID:          rd_mux = `CHIP_ID_VALUE;
         `ADDR_RST_CTRL:         rd_mux = reg_word_t'(rst_ctrl);
         `ADDR_GLBL_CFG:         rd_mux = glbl_cfg;
         `ADDR_INTR_MASK:        rd_mux = intr_mask;
         `ADDR_INTR_STAT:        rd_mux = intr_stat;
         `ADDR_MFUNC_SEL:        rd_mux = mfunc_sel;
         `ADDR_SYS_STRAP:        rd_mux = system_strap;
         `ADDR_MAILBOX:          rd_mux = mailbox;
         `ADDR_SCRATCH0:         rd_mux = scratch[0];
         `ADDR_SCRATCH0 + 5'd1:  rd_mux = scratch[1];
         `ADDR_SCRATCH0 + 5'd2:  rd_mux = scratch[2];
         `ADDR_SCRATCH0 + 5'd3:  rd_mux = scratch[3];
         // Unmapped words read as zero
         default:                rd_mux = '0;
      endcase
   end

   // ----------------------------------------
   // Acknowledge and read capture
   // ----------------------------------------
   // Ack one cycle after request, single-cycle pulse
   // Read data captured for writes too
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack   <= 1'b0;
         reg_rdata <= '0;
      end else if (reg_cs && !reg_ack) begin
         reg_ack   <= 1'b1;
         reg_rdata <= rd_mux;
      end else begin
         reg_ack   <= 1'b0;
      end
   end

endmodule

// ==== rtl/glbl_cfg_regs.sv ====
/*
 * Byte-writable configuration registers
 * Reset control, global config, interrupt mask,
 * pin select, mailbox and scratch words, plus
 * the reset, interrupt and control outputs
 */
`timescale 1ns/10ps
`include "glbl_reg_defines.svh"

module glbl_cfg_regs (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   input  glbl_reg_pkg::reg_strb_t wr_strb,
   input  glbl_reg_pkg::reg_word_t wr_data,
   input  glbl_reg_pkg::reg_be_t   wr_be,
   input  glbl_reg_pkg::strap_t    system_strap,
   // Register values for readback
   output glbl_reg_pkg::rst_ctrl_t rst_ctrl,
   output glbl_reg_pkg::reg_word_t glbl_cfg,
   output glbl_reg_pkg::intr_vec_t intr_mask,
   output glbl_reg_pkg::reg_word_t mfunc_sel,
   output glbl_reg_pkg::reg_word_t mailbox,
   output glbl_reg_pkg::reg_word_t scratch [4],
   // Reset outputs, active low
   output logic [1:0]              cpu_core_rst_n,
   output logic                    cpu_intf_rst_n,
   output logic                    qspim_rst_n,
   output logic                    sspim_rst_n,
   output logic [1:0]              uart_rst_n,
   output logic                    i2cm_rst_n,
   output logic                    usb_rst_n,
   // RISC-V side controls
   output logic                    soft_irq,
   output logic [2:0]              user_irq,
   output logic [15:0]             cfg_riscv_ctrl,
   output glbl_reg_pkg::reg_word_t cfg_multi_func_sel
);

   import glbl_reg_pkg::*;

   // Implemented bits of the reset-control field, bit 7 stays 0
   localparam rst_ctrl_t RST_DEF_MASK = rst_ctrl_t'(
      (1 << `RST_BIT_CPU_INTF) | (1 << `RST_BIT_QSPIM) | (1 << `RST_BIT_SSPIM) |
      (1 << `RST_BIT_UART0)    | (1 << `RST_BIT_I2CM)  | (1 << `RST_BIT_USB)   |
      (1 << `RST_BIT_UART1)    | (1 << `RST_BIT_CPU0)  | (1 << `RST_BIT_CPU1));

   rst_ctrl_t rst_ctrl_rst_val;
   reg_word_t glbl_cfg_rst_val;
   logic      strap_cache_byp;
   logic      strap_sram_edge;

   // Replace enabled byte lanes of cur with new data
   function automatic reg_word_t byte_merge(reg_word_t cur, reg_word_t din, reg_be_t be);
      reg_word_t res;
      res = cur;
      for (int b = 0; b < 4; b++) begin
         if (be[b])
            res[b*8 +: 8] = din[b*8 +: 8];
      end
      return res;
   endfunction

   // ----------------------------------------
   // Strap-dependent reset values
   // ----------------------------------------
   // Boot mode strap releases CPU0 from reset
   assign rst_ctrl_rst_val = system_strap[`STRAP_RISCV_RESET_MODE] ?
                             `RST_CTRL_BOOT : `RST_CTRL_HOLD;

   assign strap_cache_byp  = system_strap[`STRAP_RISCV_CACHE_BYPASS];
   assign strap_sram_edge  = system_strap[`STRAP_RISCV_SRAM_CLK_EDGE];

   // Cache bypass on 27:26, SRAM clock edge on 19:16
   assign glbl_cfg_rst_val = {4'h0, {2{strap_cache_byp}}, 6'h00,
                              {4{strap_sram_edge}}, 16'h0000};

   // ----------------------------------------
   // Register storage
   // ----------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl  <= rst_ctrl_rst_val;
         glbl_cfg  <= glbl_cfg_rst_val;
         intr_mask <= '0;
         mfunc_sel <= `MFUNC_SEL_RESET;
         mailbox   <= '0;
      end else begin
         // Only defined reset-control bits are kept
         if (wr_strb[`ADDR_RST_CTRL])
            rst_ctrl <= rst_ctrl_t'(byte_merge(reg_word_t'(rst_ctrl), wr_data, wr_be))
                        & RST_DEF_MASK;
         if (wr_strb[`ADDR_GLBL_CFG])
            glbl_cfg  <= byte_merge(glbl_cfg, wr_data, wr_be);
         if (wr_strb[`ADDR_INTR_MASK])
            intr_mask <= byte_merge(intr_mask, wr_data, wr_be);
         if (wr_strb[`ADDR_MFUNC_SEL])
            mfunc_sel <= byte_merge(mfunc_sel, wr_data, wr_be);
         if (wr_strb[`ADDR_MAILBOX])
            mailbox   <= byte_merge(mailbox, wr_data, wr_be);
      end
   end

   // Scratch words, first one carries a signature
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         scratch[0] <= `SCRATCH0_SIGNATURE;
         for (int i = 1; i < 4; i++) begin
            scratch[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (wr_strb[`ADDR_SCRATCH0 + i])
               scratch[i] <= byte_merge(scratch[i], wr_data, wr_be);
         end
      end
   end

   // ----------------------------------------
   // Output field mapping
   // ----------------------------------------
   assign cpu_intf_rst_n    = rst_ctrl[`RST_BIT_CPU_INTF];
   assign qspim_rst_n       = rst_ctrl[`RST_BIT_QSPIM];
   assign sspim_rst_n       = rst_ctrl[`RST_BIT_SSPIM];
   assign uart_rst_n[0]     = rst_ctrl[`RST_BIT_UART0];
   assign i2cm_rst_n        = rst_ctrl[`RST_BIT_I2CM];
   assign usb_rst_n         = rst_ctrl[`RST_BIT_USB];
   assign uart_rst_n[1]     = rst_ctrl[`RST_BIT_UART1];
   assign cpu_core_rst_n[0] = rst_ctrl[`RST_BIT_CPU0];
   assign cpu_core_rst_n[1] = rst_ctrl[`RST_BIT_CPU1];

   // Software and user interrupts in the low nibble
   assign soft_irq       = glbl_cfg[3];
   assign user_irq       = glbl_cfg[2:0];
   // Upper half is the RISC-V control field
   assign cfg_riscv_ctrl = glbl_cfg[31:16];

   assign cfg_multi_func_sel = mfunc_sel;

endmodule

// ==== rtl/intr_stat_ctrl.sv ====
/*
 * Interrupt status logic
 * Request assembly, sticky status with
 * write-1-clear and masked interrupt lines
 */
`timescale 1ns/10ps
`include "glbl_reg_defines.svh"

module intr_stat_ctrl (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   input  glbl_reg_pkg::reg_strb_t wr_strb,
   input  glbl_reg_pkg::reg_word_t wr_data,
   input  glbl_reg_pkg::reg_be_t   wr_be,
   input  glbl_reg_pkg::intr_vec_t intr_mask,
   // Hardware interrupt sources
   input  logic [2:0]              timer_intr,
   input  logic                    i2cm_intr,
   input  logic                    usb_intr,
   input  glbl_reg_pkg::intr_vec_t gpio_intr,
   output glbl_reg_pkg::intr_vec_t intr_stat,
   output glbl_reg_pkg::intr_vec_t irq_lines
);

   import glbl_reg_pkg::*;

   intr_vec_t intr_req;
   intr_vec_t intr_clr;

   // ----------------------------------------
   // Request vector
   // ----------------------------------------
   // GPIO 7:0 belong to a port with no user access
   assign intr_req = {gpio_intr[31:8], 3'b000, usb_intr, i2cm_intr, timer_intr};

   // Clear bits, only where a 1 lands in an enabled lane
   always_comb begin
      intr_clr = '0;
      for (int b = 0; b < 4; b++) begin
         if (wr_strb[`ADDR_INTR_STAT] && wr_be[b])
            intr_clr[b*8 +: 8] = wr_data[b*8 +: 8];
      end
   end

   // ----------------------------------------
   // Sticky status
   // ----------------------------------------
   // Set wins over a clear in the same cycle
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n)
         intr_stat <= '0;
      else
         intr_stat <= (intr_stat & ~intr_clr) | intr_req;
   end

   // Lines follow status and mask registers directly
   assign irq_lines = intr_stat & intr_mask;

endmodule

// ==== rtl/glbl_reg.sv ====
/*
 * Global register block top level
 * Bus slave, configuration registers and
 * interrupt status logic wired together
 */
`timescale 1ns/10ps

module glbl_reg (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   input  glbl_reg_pkg::strap_t    system_strap,
   // Register bus
   input  logic                    reg_cs,
   input  logic                    reg_wr,
   input  glbl_reg_pkg::reg_addr_t reg_addr,
   input  glbl_reg_pkg::reg_word_t reg_wdata,
   input  glbl_reg_pkg::reg_be_t   reg_be,
   output glbl_reg_pkg::reg_word_t reg_rdata,
   output logic                    reg_ack,
   // Interrupt sources
   input  logic [2:0]              timer_intr,
   input  logic                    i2cm_intr,
   input  logic                    usb_intr,
   input  glbl_reg_pkg::intr_vec_t gpio_intr,
   // Reset outputs, active low
   output logic [1:0]              cpu_core_rst_n,
   output logic                    cpu_intf_rst_n,
   output logic                    qspim_rst_n,
   output logic                    sspim_rst_n,
   output logic [1:0]              uart_rst_n,
   output logic                    i2cm_rst_n,
   output logic                    usb_rst_n,
   // RISC-V configuration
   output logic                    soft_irq,
   output logic [2:0]              user_irq,
   output logic [15:0]             cfg_riscv_ctrl,
   output glbl_reg_pkg::reg_word_t cfg_multi_func_sel,
   output glbl_reg_pkg::intr_vec_t irq_lines
);

   import glbl_reg_pkg::*;

   // Write path
   reg_strb_t wr_strb;
   reg_word_t wr_data;
   reg_be_t   wr_be;

   // Register values back to the read mux
   rst_ctrl_t rst_ctrl;
   reg_word_t glbl_cfg;
   intr_vec_t intr_mask;
   intr_vec_t intr_stat;
   reg_word_t mfunc_sel;
   reg_word_t mailbox;
   reg_word_t scratch [4];

   reg_bus_ctrl u_bus (
      .mclk, .s_reset_n,
      .reg_cs, .reg_wr, .reg_addr, .reg_wdata, .reg_be,
      .system_strap, .rst_ctrl, .glbl_cfg, .intr_mask, .intr_stat,
      .mfunc_sel, .mailbox, .scratch,
      .wr_strb, .wr_data, .wr_be,
      .reg_rdata, .reg_ack
   );

   // Mask steers the status block beside it
   glbl_cfg_regs u_cfg (
      .mclk, .s_reset_n,
      .wr_strb, .wr_data, .wr_be, .system_strap,
      .rst_ctrl, .glbl_cfg, .intr_mask, .mfunc_sel, .mailbox, .scratch,
      .cpu_core_rst_n, .cpu_intf_rst_n, .qspim_rst_n, .sspim_rst_n,
      .uart_rst_n, .i2cm_rst_n, .usb_rst_n,
      .soft_irq, .user_irq, .cfg_riscv_ctrl, .cfg_multi_func_sel
   );

   intr_stat_ctrl u_intr (
      .mclk, .s_reset_n,
      .wr_strb, .wr_data, .wr_be, .intr_mask,
      .timer_intr, .i2cm_intr, .usb_intr, .gpio_intr,
      .intr_stat, .irq_lines
   );

endmodule

// ==== testbench/tb_glbl_model.svh ====
/*
 * Register model for the global register testbench
 * Shadow registers, strap reset values, byte-lane
 * writes, write-1-clear status and read decode
 */
`ifndef TB_GLBL_MODEL_SVH
`define TB_GLBL_MODEL_SVH

// Defined reset-control bits 0 to 6, 8 and 9
localparam rst_ctrl_t M_RST_BITS = 10'b11_0111_1111;

strap_t    m_strap;
rst_ctrl_t m_rst;
reg_word_t m_cfg;
intr_vec_t m_mask;
intr_vec_t m_stat;
reg_word_t m_mfunc;
reg_word_t m_mailbox;
reg_word_t m_scratch [4];

// One byte of ones per enabled lane
function automatic reg_word_t lane_mask(reg_be_t be);
   return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

function automatic reg_word_t lane_write(reg_word_t old, reg_word_t din, reg_be_t be);
   return (old & ~lane_mask(be)) | (din & lane_mask(be));
endfunction

// Request bit map, bits 7 to 5 and gpio 7 to 0 unused
function automatic intr_vec_t hw_request(logic [2:0] tmr, logic i2c, logic usb, intr_vec_t gpio);
   intr_vec_t req;
   req      = gpio;
   req[7:0] = {3'b000, usb, i2c, tmr};
   return req;
endfunction

task automatic model_reset(input strap_t strap);
   m_strap      = strap;
   m_rst        = strap[`STRAP_RISCV_RESET_MODE] ? `RST_CTRL_BOOT : `RST_CTRL_HOLD;
   m_cfg        = '0;
   // Cache bypass strap copied to 27 and 26
   m_cfg[27]    = strap[`STRAP_RISCV_CACHE_BYPASS];
   m_cfg[26]    = strap[`STRAP_RISCV_CACHE_BYPASS];
   m_cfg[19:16] = {4{strap[`STRAP_RISCV_SRAM_CLK_EDGE]}};
   m_mask       = '0;
   m_stat       = '0;
   m_mfunc      = `MFUNC_SEL_RESET;
   m_mailbox    = '0;
   m_scratch[0] = `SCRATCH0_SIGNATURE;
   for (int i = 1; i < 4; i++) begin
      m_scratch[i] = '0;
   end
endtask

task automatic model_write(input reg_addr_t addr, input reg_word_t data, input reg_be_t be);
   case (addr)
      `ADDR_RST_CTRL:
         m_rst = rst_ctrl_t'(lane_write(reg_word_t'(m_rst), data, be)) & M_RST_BITS;
      `ADDR_GLBL_CFG:  m_cfg     = lane_write(m_cfg, data, be);
      `ADDR_INTR_MASK: m_mask    = lane_write(m_mask, data, be);
      // Ones in enabled lanes clear status
      `ADDR_INTR_STAT: m_stat    = m_stat & ~(data & lane_mask(be));
      `ADDR_MFUNC_SEL: m_mfunc   = lane_write(m_mfunc, data, be);
      `ADDR_MAILBOX:   m_mailbox = lane_write(m_mailbox, data, be);
      default: begin
         if (addr >= 16 && addr <= 19)
            m_scratch[addr - 16] = lane_write(m_scratch[addr - 16], data, be);
      end
   endcase
endtask

function automatic reg_word_t model_read(reg_addr_t addr);
   case (addr)
      `ADDR_CHIP_ID:   return `CHIP_ID_VALUE;
      `ADDR_RST_CTRL:  return reg_word_t'(m_rst);
      `ADDR_GLBL_CFG:  return m_cfg;
      `ADDR_INTR_MASK: return m_mask;
      `ADDR_INTR_STAT: return m_stat;
      `ADDR_MFUNC_SEL: return m_mfunc;
      `ADDR_SYS_STRAP: return m_strap;
      `ADDR_MAILBOX:   return m_mailbox;
      default:         return (addr >= 16 && addr <= 19) ? m_scratch[addr - 16] : '0;
   endcase
endfunction

`endif

// ==== testbench/tb_glbl_reg.sv ====
/*
 * Testbench for the global register block
 * Clock, reset, bus tasks, compare tasks,
 * random stimulus phases and watchdog
 */
`timescale 1ns/10ps
`include "glbl_reg_defines.svh"

module tb_glbl_reg;

   import glbl_reg_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int N_WR       = 150;
   localparam int N_INTR     = 60;
   // Worst case 5 cycles per access or pulse
   localparam int TEST_CYCLES = 2 * (6 + 22 * 5) + 5 * (2 * N_WR + 3 + 6 * N_INTR);

   logic        mclk, s_reset_n, reg_cs, reg_wr, reg_ack;
   logic        i2cm_intr, usb_intr, cpu_intf_rst_n, qspim_rst_n, sspim_rst_n;
   logic        i2cm_rst_n, usb_rst_n, soft_irq;
   logic [1:0]  cpu_core_rst_n, uart_rst_n;
   logic [2:0]  timer_intr, user_irq;
   logic [15:0] cfg_riscv_ctrl;
   reg_addr_t   reg_addr;
   reg_word_t   reg_wdata, reg_rdata, cfg_multi_func_sel;
   reg_be_t     reg_be;
   strap_t      system_strap;
   intr_vec_t   gpio_intr, irq_lines;

   `include "tb_glbl_model.svh"

   glbl_reg u_glbl_reg (.*);

   initial begin
      mclk = 1'b0;
      forever #(CLK_PERIOD / 2) mclk = ~mclk;
   end

   // ----------------------------------------
   // Failure reporting and compare tasks
   // ----------------------------------------
   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input reg_word_t got, input reg_word_t exp, input string what);
      if (got !== exp)
         stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_intr(input intr_vec_t got, input intr_vec_t exp, input string what);
      if (got !== exp)
         stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_rst(input rst_ctrl_t got, input rst_ctrl_t exp, input string what);
      if (got !== exp)
         stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
   endtask

   // All register-driven outputs against the model
   task automatic check_outputs();
      rst_ctrl_t rst_got;
      rst_got = {cpu_core_rst_n, 1'b0, uart_rst_n[1], usb_rst_n, i2cm_rst_n,
                 uart_rst_n[0], sspim_rst_n, qspim_rst_n, cpu_intf_rst_n};
      check_rst(rst_got, m_rst, "reset outputs");
      check_word({cfg_riscv_ctrl, 12'h000, soft_irq, user_irq},
                 {m_cfg[31:16], 12'h000, m_cfg[3:0]}, "riscv ctrl and irq outputs");
      check_word(cfg_multi_func_sel, m_mfunc, "cfg_multi_func_sel");
      check_intr(irq_lines, m_stat & m_mask, "irq_lines");
   endtask

   // ----------------------------------------
   // Bus tasks
   // ----------------------------------------
   task automatic bus_access(input logic wr, input reg_addr_t addr, input reg_word_t wdata,
                             input reg_be_t be, output reg_word_t rdata);
      int waits;
      @(negedge mclk);
      // Ack must have dropped after one cycle
      if (reg_ack)
         stop_run("reg_ack stayed high longer than one cycle");
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_wdata = wdata;
      reg_be    = be;
      @(negedge mclk);
      waits = 1;
      while (!reg_ack && waits < 4) begin
         @(negedge mclk);
         waits++;
      end
      if (!reg_ack)
         stop_run($sformatf("No acknowledge within 4 cycles for address %0d", addr));
      rdata  = reg_rdata;
      reg_cs = 1'b0;
      reg_wr = 1'b0;
   endtask

   // Write-cycle read data shows the old contents
   task automatic write_reg(input reg_addr_t addr, input reg_word_t data, input reg_be_t be);
      reg_word_t rd;
      bus_access(1'b1, addr, data, be, rd);
      check_word(rd, model_read(addr), $sformatf("write data phase of address %0d", addr));
      model_write(addr, data, be);
      check_outputs();
   endtask

   task automatic read_reg(input reg_addr_t addr);
      reg_word_t rd;
      bus_access(1'b0, addr, '0, 4'hf, rd);
      if (addr == `ADDR_INTR_STAT)
         check_intr(rd, m_stat, "interrupt status read");
      else
         check_word(rd, model_read(addr), $sformatf("read of address %0d", addr));
      check_outputs();
   endtask

   // One-cycle pulse of sparse random requests
   task automatic pulse_intr();
      @(negedge mclk);
      timer_intr = 3'($urandom & $urandom);
      i2cm_intr  = ($urandom_range(0, 3) == 0);
      usb_intr   = ($urandom_range(0, 3) == 0);
      gpio_intr  = $urandom & $urandom & $urandom;
      m_stat     = m_stat | hw_request(timer_intr, i2cm_intr, usb_intr, gpio_intr);
      @(negedge mclk);
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      gpio_intr  = '0;
      check_outputs();
   endtask

   // Reset-mode strap bit alternates between runs
   task automatic apply_reset(input int run);
      strap_t strap;
      strap = $urandom;
      strap[`STRAP_RISCV_RESET_MODE] = run[0];
      @(negedge mclk);
      // Strap settles before reset goes low and holds through it
      system_strap = strap;
      s_reset_n    = 1'b0;
      repeat (5) @(negedge mclk);
      s_reset_n = 1'b1;
      model_reset(strap);
      if (reg_ack)
         stop_run("reg_ack is high after reset");
      check_word(reg_rdata, '0, "reg_rdata after reset");
      check_outputs();
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      reg_addr_t addr;
      void'($urandom(77611));
      s_reset_n    = 1'b1;
      reg_cs       = 1'b0;
      reg_wr       = 1'b0;
      reg_addr     = '0;
      reg_wdata    = '0;
      reg_be       = '0;
      system_strap = '0;
      timer_intr   = '0;
      i2cm_intr    = 1'b0;
      usb_intr     = 1'b0;
      gpio_intr    = '0;

      // Reset values with 6 to 13 and above 19 unmapped
      for (int run = 0; run < 2; run++) begin
         apply_reset(run);
         for (int a = 0; a < 20; a++) begin
            read_reg(reg_addr_t'(a));
         end
         read_reg(5'd21);
         read_reg(5'd31);
      end

      // Byte-enable writes with readback
      repeat (N_WR) begin
         addr = reg_addr_t'($urandom_range(0, 19));
         write_reg(addr, $urandom, reg_be_t'($urandom));
         read_reg(addr);
      end

      // Sticky status set by hardware pulses
      write_reg(`ADDR_INTR_STAT, '1, 4'hf);
      repeat (N_INTR) begin
         pulse_intr();
         read_reg(`ADDR_INTR_STAT);
      end

      // Write-1-clear under a random mask
      write_reg(`ADDR_INTR_MASK, $urandom, 4'hf);
      repeat (N_INTR) begin
         if ($urandom_range(0, 3) == 0)
            pulse_intr();
         if ($urandom_range(0, 7) == 0)
            write_reg(`ADDR_INTR_MASK, $urandom, reg_be_t'($urandom));
         write_reg(`ADDR_INTR_STAT, $urandom, reg_be_t'($urandom));
         read_reg(`ADDR_INTR_STAT);
      end

      $display("SIMULATION PASSED");
      $finish;
   end

   // Watchdog at twice the worst-case sequence length
   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      stop_run("Watchdog timeout, the test sequence did not complete in time");
   end

endmodule

// ==== tb.f ====
+incdir+rtl
+incdir+testbench
rtl/glbl_reg_pkg.sv
rtl/reg_bus_ctrl.sv
rtl/glbl_cfg_regs.sv
rtl/intr_stat_ctrl.sv
rtl/glbl_reg.sv
testbench/tb_glbl_reg.sv
